// File: hdl/arm_settings.svh
`ifndef ARM_SETTINGS_SVH
`define ARM_SETTINGS_SVH

// Byte address width of the RAM, 16 KiB
`define ARM_RAM_AW 14

// Idle cycles between cs and ready
`define ARM_RAM_WAIT 1

`endif

// File: hdl/arm_pkg.sv
package arm_pkg;

    // Word must stay 2'b11, the loader writes with it
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b11
    } mem_size_e;

    typedef enum logic [3:0] {
        COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
        COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL, COND_NV
    } cond_e;

    typedef enum logic [3:0] {
        DP_AND, DP_EOR, DP_SUB, DP_RSB, DP_ADD, DP_ADC, DP_SBC, DP_RSC,
        DP_TST, DP_TEQ, DP_CMP, DP_CMN, DP_ORR, DP_MOV, DP_BIC, DP_MVN
    } dp_op_e;

    // Class tags, bits 27 down
    localparam logic [1:0] CLS_DP  = 2'b00;
    localparam logic [1:0] CLS_LS  = 2'b01;
    localparam logic [2:0] CLS_BR  = 3'b101;
    localparam logic [3:0] SWI_TAG = 4'hF;   // Class and link bit together

    typedef struct packed {
        cond_e       cond;
        logic [1:0]  cls;
        logic        imm;
        dp_op_e      opcode;
        logic        s;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] operand2;   // imm8 in [7:0] or rm in [3:0]
    } dp_instr_t;

    typedef struct packed {
        cond_e       cond;
        logic [1:0]  cls;
        logic        i;
        logic        p;
        logic        u;
        logic        b;
        logic        w;
        logic        l;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [11:0] offset12;
    } ls_instr_t;

    typedef struct packed {
        cond_e       cond;
        logic [2:0]  cls;
        logic        link;
        logic [23:0] offset24;   // Word offset from pc+8
    } br_instr_t;

    typedef union packed {
        dp_instr_t   dp;
        ls_instr_t   ls;
        br_instr_t   br;
        logic [31:0] raw;
    } instr_u;

endpackage

// File: hdl/mem_bus_if.sv
`timescale 1ns/100ps
`include "arm_settings.svh"

interface mem_bus_if;
    import arm_pkg::*;

    logic                   cs;
    logic                   we;
    logic [`ARM_RAM_AW-1:0] addr;    // Byte address
    logic [31:0]            wdata;
    mem_size_e              size;
    logic [31:0]            rdata;   // Valid with ready
    logic                   ready;   // One-cycle pulse

    modport master (
        output cs, we, addr, wdata, size,
        input  rdata, ready
    );

    modport slave (
        input  cs, we, addr, wdata, size,
        output rdata, ready
    );

endinterface

// File: hdl/boot_loader.sv
`timescale 1ns/100ps
`include "arm_settings.svh"

module boot_loader (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        load_valid,
    input  logic        load_last,
    input  logic [31:0] load_data,
    mem_bus_if.slave    core_bus,
    mem_bus_if.master   ram_bus,
    output logic        core_run,
    output logic        boot_done
);
    import arm_pkg::*;

    logic                   pending;   // Write waiting for ready
    logic                   last_q;
    logic                   done;
    logic [`ARM_RAM_AW-3:0] wr_idx;
    logic [31:0]            wr_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            last_q  <= 1'b0;
            done    <= 1'b0;
            wr_idx  <= '0;
        end else if (pending) begin
            if (ram_bus.ready) begin
                pending <= 1'b0;
                wr_idx  <= wr_idx + 1'b1;
                done    <= last_q;
            end
        end else if (load_valid && !done) begin
            pending <= 1'b1;
            last_q  <= load_last;
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid && !pending) begin
            wr_data <= load_data;
        end
    end

    // Loader owns the RAM until the image is in
    assign ram_bus.cs     = done ? core_bus.cs    : pending;
    assign ram_bus.we     = done ? core_bus.we    : 1'b1;
    assign ram_bus.addr   = done ? core_bus.addr  : {wr_idx, 2'b00};
    assign ram_bus.wdata  = done ? core_bus.wdata : wr_data;
    assign ram_bus.size   = done ? core_bus.size  : SIZE_WORD;
    assign core_bus.rdata = ram_bus.rdata;
    assign core_bus.ready = done && ram_bus.ready;

    assign core_run  = done;
    assign boot_done = done;

    a_strobe_while_pending: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid |-> !pending)
        else $error("load strobe while a RAM write is pending");

    a_strobe_after_done: assert property (@(posedge clk) disable iff (!rst_n)
        load_valid |-> !done)
        else $error("load strobe after boot finished");

endmodule

// File: hdl/basic_ram.sv
`timescale 1ns/100ps
`include "arm_settings.svh"

module basic_ram (
    input  logic     clk,
    input  logic     rst_n,
    mem_bus_if.slave bus
);
    import arm_pkg::*;

    localparam int WORDS = 2 ** (`ARM_RAM_AW - 2);
    localparam int WAIT  = `ARM_RAM_WAIT;
    localparam int CW    = (WAIT > 0) ? $clog2(WAIT + 1) : 1;

    logic [31:0]            mem [WORDS];
    logic [`ARM_RAM_AW-3:0] word_idx;
    logic [1:0]             byte_off;
    logic [31:0]            rd_word;
    logic [CW-1:0]          wait_cnt;
    logic                   fire;

    assign word_idx = bus.addr[`ARM_RAM_AW-1:2];
    assign byte_off = bus.addr[1:0];
    assign rd_word  = mem[word_idx];

    // Access happens on the edge that raises ready
    assign fire = bus.cs && !bus.ready && (wait_cnt == CW'(WAIT));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt  <= '0;
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= 1'b0;
            if (fire) begin
                wait_cnt  <= '0;
                bus.ready <= 1'b1;
            end else if (bus.cs && !bus.ready) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire && bus.we) begin
            case (bus.size)
                SIZE_BYTE: mem[word_idx][{byte_off, 3'b000} +: 8]     <= bus.wdata[7:0];
                SIZE_HALF: mem[word_idx][{byte_off[1], 4'b0000} +: 16] <= bus.wdata[15:0];
                default:   mem[word_idx] <= bus.wdata;
            endcase
        end
        if (fire && !bus.we) begin
            case (bus.size)
                SIZE_BYTE: bus.rdata <= {24'h0, rd_word[{byte_off, 3'b000} +: 8]};
                SIZE_HALF: bus.rdata <= {16'h0, rd_word[{byte_off[1], 4'b0000} +: 16]};
                default:   bus.rdata <= rd_word;
            endcase
        end
    end

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        bus.cs && bus.size == SIZE_WORD |-> bus.addr[1:0] == 2'b00)
        else $error("unaligned word access at %h", bus.addr);

    a_cs_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus.cs && !bus.ready |=> bus.cs)
        else $error("cs dropped before ready");

endmodule

// File: hdl/arm_core.sv
`timescale 1ns/100ps
`include "arm_settings.svh"

module arm_core (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               run,
    mem_bus_if.master          bus,
    output logic               halted,
    output logic               retire_valid,
    output logic [31:0]        retire_pc,
    output logic [31:0]        retire_instr,
    output logic               retire_rd_we,
    output logic [3:0]         retire_rd,
    output logic [31:0]        retire_rd_value,
    output logic               retire_st,
    output logic [31:0]        retire_addr,
    output logic [31:0]        retire_st_data,
    output arm_pkg::mem_size_e retire_st_size
);
    import arm_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } state_e;

    state_e      state;
    instr_u      ir;
    logic [31:0] pc;
    logic [31:0] regs [15];   // r15 is pc
    logic        flag_n;
    logic        flag_z;
    logic        flag_c;
    logic        flag_v;

    logic [31:0] pc_plus8;
    logic [31:0] rn_val;
    logic [31:0] rm_val;
    logic [31:0] rd_val;
    logic [31:0] op2;
    logic [31:0] alu_res;
    logic        alu_c;
    logic        alu_v;
    logic        cond_ok;
    logic        is_dp;
    logic        is_ls;
    logic        is_br;
    logic        is_swi;
    logic        dp_wr;
    logic        dp_flags;
    logic [31:0] ls_addr;
    logic [31:0] st_data;
    logic [31:0] br_target;
    mem_size_e   ls_size;

    assign pc_plus8 = pc + 32'd8;
    assign rn_val   = (ir.dp.rn == 4'd15) ? pc_plus8 : regs[ir.dp.rn];
    assign rm_val   = (ir.dp.operand2[3:0] == 4'd15) ? pc_plus8 : regs[ir.dp.operand2[3:0]];
    assign rd_val   = (ir.dp.rd == 4'd15) ? pc_plus8 : regs[ir.dp.rd];

    assign is_dp  = ir.dp.cls == CLS_DP;
    assign is_ls  = ir.ls.cls == CLS_LS;
    assign is_br  = ir.br.cls == CLS_BR;
    assign is_swi = {ir.br.cls, ir.br.link} == SWI_TAG;

    always_comb begin
        case (ir.dp.cond)
            COND_EQ: cond_ok = flag_z;
            COND_NE: cond_ok = !flag_z;
            COND_CS: cond_ok = flag_c;
            COND_CC: cond_ok = !flag_c;
            COND_MI: cond_ok = flag_n;
            COND_PL: cond_ok = !flag_n;
            COND_VS: cond_ok = flag_v;
            COND_VC: cond_ok = !flag_v;
            COND_HI: cond_ok = flag_c && !flag_z;
            COND_LS: cond_ok = !flag_c || flag_z;
            COND_GE: cond_ok = flag_n == flag_v;
            COND_LT: cond_ok = flag_n != flag_v;
            COND_GT: cond_ok = !flag_z && (flag_n == flag_v);
            COND_LE: cond_ok = flag_z || (flag_n != flag_v);
            default: cond_ok = 1'b1;
        endcase
    end

    assign op2 = ir.dp.imm ? {24'h0, ir.dp.operand2[7:0]} : rm_val;

    always_comb begin
        alu_res = rn_val;
        alu_c   = flag_c;   // Logical ops keep C and V
        alu_v   = flag_v;
        case (ir.dp.opcode)
            DP_AND: alu_res = rn_val & op2;
            DP_ORR: alu_res = rn_val | op2;
            DP_MOV: alu_res = op2;
            DP_ADD: begin
                {alu_c, alu_res} = {1'b0, rn_val} + {1'b0, op2};
                alu_v = (rn_val[31] == op2[31]) && (alu_res[31] != rn_val[31]);
            end
            DP_SUB, DP_CMP: begin
                {alu_c, alu_res} = {1'b0, rn_val} + {1'b0, ~op2} + 33'd1;   // C is not-borrow
                alu_v = (rn_val[31] != op2[31]) && (alu_res[31] != rn_val[31]);
            end
            default: alu_res = rn_val;
        endcase
    end

    assign dp_wr    = ir.dp.opcode inside {DP_AND, DP_SUB, DP_ADD, DP_ORR, DP_MOV};
    assign dp_flags = (ir.dp.s && dp_wr) || ir.dp.opcode == DP_CMP;

    assign ls_addr   = ir.ls.u ? rn_val + {20'h0, ir.ls.offset12}
                               : rn_val - {20'h0, ir.ls.offset12};
    assign ls_size   = ir.ls.b ? SIZE_BYTE : SIZE_WORD;
    assign st_data   = ir.ls.b ? {24'h0, rd_val[7:0]} : rd_val;
    assign br_target = pc_plus8 + {{6{ir.br.offset24[23]}}, ir.br.offset24, 2'b00};

    // Fetch sits out the retire cycle so cs drops between requests
    assign bus.cs    = (state == S_FETCH && !retire_valid) || state == S_MEM;
    assign bus.we    = state == S_MEM && !ir.ls.l;
    assign bus.addr  = (state == S_MEM) ? ls_addr[`ARM_RAM_AW-1:0] : pc[`ARM_RAM_AW-1:0];
    assign bus.wdata = st_data;
    assign bus.size  = (state == S_MEM) ? ls_size : SIZE_WORD;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            pc           <= 32'd0;
            flag_n       <= 1'b0;
            flag_z       <= 1'b0;
            flag_c       <= 1'b0;
            flag_v       <= 1'b0;
            halted       <= 1'b0;
            retire_valid <= 1'b0;
            retire_rd_we <= 1'b0;
            retire_st    <= 1'b0;
            for (int i = 0; i < 15; i++) begin
                regs[i] <= 32'd0;
            end
        end else begin
            retire_valid <= 1'b0;
            retire_rd_we <= 1'b0;
            retire_st    <= 1'b0;
            case (state)
                S_IDLE: if (run) state <= S_FETCH;
                S_FETCH: if (bus.ready) state <= S_EXEC;
                S_EXEC: begin
                    retire_valid <= 1'b1;
                    pc           <= pc + 32'd4;
                    state        <= S_FETCH;
                    if (cond_ok) begin
                        if (is_swi) begin
                            state <= S_HALT;
                        end else if (is_ls) begin
                            retire_valid <= 1'b0;   // Retires after the access
                            pc           <= pc;
                            state        <= S_MEM;
                        end else if (is_br) begin
                            pc <= br_target;
                        end else if (is_dp) begin
                            if (dp_wr) begin
                                retire_rd_we <= 1'b1;
                                if (ir.dp.rd == 4'd15) pc <= alu_res;
                                else regs[ir.dp.rd] <= alu_res;
                            end
                            if (dp_flags) begin
                                flag_n <= alu_res[31];
                                flag_z <= alu_res == 32'd0;
                                flag_c <= alu_c;
                                flag_v <= alu_v;
                            end
                        end
                    end
                end
                S_MEM: begin
                    if (bus.ready) begin
                        retire_valid <= 1'b1;
                        pc           <= pc + 32'd4;
                        state        <= S_FETCH;
                        if (ir.ls.l) begin
                            retire_rd_we <= 1'b1;
                            if (ir.ls.rd == 4'd15) pc <= bus.rdata;
                            else regs[ir.ls.rd] <= bus.rdata;
                        end else begin
                            retire_st <= 1'b1;
                        end
                    end
                end
                S_HALT: halted <= 1'b1;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && bus.ready) begin
            ir <= bus.rdata;
        end
        if (state == S_EXEC) begin
            retire_pc       <= pc;
            retire_instr    <= ir;
            retire_rd       <= ir.dp.rd;
            retire_rd_value <= alu_res;
            retire_addr     <= ls_addr;
            retire_st_data  <= st_data;
            retire_st_size  <= ls_size;
        end else if (state == S_MEM && bus.ready && ir.ls.l) begin
            retire_rd_value <= bus.rdata;   // Zero-extended by the RAM
        end
    end

endmodule

// File: hdl/arm_system.sv
`timescale 1ns/100ps

module arm_system (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               load_valid,
    input  logic [31:0]        load_data,
    input  logic               load_last,
    output logic               boot_done,
    output logic               halted,
    output logic               retire_valid,
    output logic [31:0]        retire_pc,
    output logic [31:0]        retire_instr,
    output logic               retire_rd_we,
    output logic [3:0]         retire_rd,
    output logic [31:0]        retire_rd_value,
    output logic               retire_st,
    output logic [31:0]        retire_addr,
    output logic [31:0]        retire_st_data,
    output arm_pkg::mem_size_e retire_st_size
);

    mem_bus_if core_bus ();
    mem_bus_if ram_bus ();

    logic core_run;

    arm_core arm_core_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .run             (core_run),
        .bus             (core_bus.master),
        .halted          (halted),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_instr    (retire_instr),
        .retire_rd_we    (retire_rd_we),
        .retire_rd       (retire_rd),
        .retire_rd_value (retire_rd_value),
        .retire_st       (retire_st),
        .retire_addr     (retire_addr),
        .retire_st_data  (retire_st_data),
        .retire_st_size  (retire_st_size)
    );

    // Loader sits between core and RAM
    boot_loader boot_loader_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_valid (load_valid),
        .load_last  (load_last),
        .load_data  (load_data),
        .core_bus   (core_bus.slave),
        .ram_bus    (ram_bus.master),
        .core_run   (core_run),
        .boot_done  (boot_done)
    );

    basic_ram basic_ram_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (ram_bus.slave)
    );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD_NS = 8.0
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

// File: dv/tb_arm_system.sv
`timescale 1ns/100ps
`include "arm_settings.svh"

module tb_arm_system;
    import arm_pkg::*;

    localparam int IMG_WORDS  = 256;     // Code at 0 and data in 0x200 to 0x3ff
    localparam int DATA_BASE  = 'h200;
    localparam int NUM_TESTS  = 10;
    localparam int BOOT_LIMIT = 32;
    localparam int RUN_LIMIT  = 4000;
    localparam int QUIET      = 20;

    logic        clk;
    logic        rst_n;
    logic        load_valid;
    logic [31:0] load_data;
    logic        load_last;
    logic        boot_done;
    logic        halted;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [31:0] retire_instr;
    logic        retire_rd_we;
    logic [3:0]  retire_rd;
    logic [31:0] retire_rd_value;
    logic        retire_st;
    logic [31:0] retire_addr;
    logic [31:0] retire_st_data;
    mem_size_e   retire_st_size;

    logic [31:0] image [IMG_WORDS];
    logic [31:0] mem_model [int];   // Word index to contents
    logic [31:0] m_regs [16];
    logic [31:0] m_pc;
    logic        m_n;
    logic        m_z;
    logic        m_c;
    logic        m_v;
    bit          model_done;
    int          exec_count;
    int          retire_count;
    string       test_name;

    tb_clock_gen clock_gen_inst (.clk(clk));

    arm_system arm_system_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .load_valid      (load_valid),
        .load_data       (load_data),
        .load_last       (load_last),
        .boot_done       (boot_done),
        .halted          (halted),
        .retire_valid    (retire_valid),
        .retire_pc       (retire_pc),
        .retire_instr    (retire_instr),
        .retire_rd_we    (retire_rd_we),
        .retire_rd       (retire_rd),
        .retire_rd_value (retire_rd_value),
        .retire_st       (retire_st),
        .retire_addr     (retire_addr),
        .retire_st_data  (retire_st_data),
        .retire_st_size  (retire_st_size)
    );

    // Every retire pulse since the last reset
    always @(negedge clk) begin
        if (!rst_n) begin
            retire_count = 0;
        end else if (retire_valid) begin
            retire_count++;
        end
    end

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(string what, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_true(bit ok, string what);
        assert (ok) else begin
            $display("Error in %s: %s", test_name, what);
            stop_on_error();
        end
    endtask

    function automatic dp_op_e pick_dp_op();
        case ($urandom_range(0, 5))
            0: return DP_AND;
            1: return DP_SUB;
            2: return DP_ADD;
            3: return DP_ORR;
            4: return DP_MOV;
            default: return DP_CMP;
        endcase
    endfunction

    function automatic logic [31:0] reg_read(logic [3:0] r);
        return (r == 4'd15) ? m_pc + 32'd8 : m_regs[r];
    endfunction

    // Odd codes invert the even code below them
    function automatic bit cond_pass(logic [3:0] c);
        bit base;
        case (c[3:1])
            3'd0: base = m_z;
            3'd1: base = m_c;
            3'd2: base = m_n;
            3'd3: base = m_v;
            3'd4: base = m_c && !m_z;
            3'd5: base = m_n == m_v;
            3'd6: base = !m_z && (m_n == m_v);
            default: return 1'b1;
        endcase
        return base ^ c[0];
    endfunction

    task automatic build_program();
        instr_u u;
        int     n;
        int     kind;
        int     hi;
        int     off;
        n = $urandom_range(20, 40);
        for (int i = 0; i < IMG_WORDS; i++) begin
            image[i] = $urandom();   // Filler doubles as initial data
        end
        for (int i = 0; i < n; i++) begin
            u.raw = 32'h0;
            u.dp.cond = ($urandom_range(0, 9) < 6) ? COND_AL : cond_e'($urandom_range(0, 13));
            kind = $urandom_range(0, 19);
            if (kind < 11) begin
                u.dp.cls      = CLS_DP;
                u.dp.imm      = 1'($urandom_range(0, 1));
                u.dp.opcode   = pick_dp_op();
                u.dp.s        = (u.dp.opcode == DP_CMP) ? 1'b1 : 1'($urandom_range(0, 1));
                u.dp.rn       = (u.dp.opcode == DP_MOV) ? 4'd0 : 4'($urandom_range(0, 7));
                u.dp.rd       = (u.dp.opcode == DP_CMP) ? 4'd0 : 4'($urandom_range(0, 7));
                u.dp.operand2 = u.dp.imm ? 12'($urandom_range(0, 255)) : 12'($urandom_range(0, 7));
            end else if (kind < 17) begin
                u.ls.cls = CLS_LS;
                u.ls.p   = 1'b1;
                u.ls.u   = 1'b1;
                u.ls.b   = 1'($urandom_range(0, 1));
                u.ls.l   = 1'($urandom_range(0, 1));
                u.ls.rn  = 4'd8;   // Nothing writes r8 so it stays zero
                u.ls.rd  = 4'($urandom_range(0, 7));
                if (u.ls.b) u.ls.offset12 = 12'(DATA_BASE + $urandom_range(0, 511));
                else u.ls.offset12 = 12'(DATA_BASE + 4 * $urandom_range(0, 127));
            end else begin
                hi = (n - i - 2 < 3) ? n - i - 2 : 3;   // Never past the SWI
                off = int'($urandom_range(0, hi + 1)) - 1;
                u.br.cls      = CLS_BR;
                u.br.link     = 1'b0;
                u.br.offset24 = 24'(off);
            end
            image[i] = u.raw;
        end
        u.raw     = 32'h0;
        u.br.cond = COND_AL;
        u.br.cls  = 3'b111;
        u.br.link = 1'b1;
        image[n]  = u.raw;
    endtask

    task automatic reset_model();
        mem_model.delete();
        for (int i = 0; i < IMG_WORDS; i++) begin
            mem_model[i] = image[i];
        end
        for (int i = 0; i < 16; i++) begin
            m_regs[i] = 32'h0;
        end
        m_pc       = 32'h0;
        m_n        = 1'b0;
        m_z        = 1'b0;
        m_c        = 1'b0;
        m_v        = 1'b0;
        model_done = 1'b0;
        exec_count = 0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n      <= 1'b0;
        load_valid <= 1'b0;
        load_last  <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic stream_image();
        int gap;
        for (int i = 0; i < IMG_WORDS; i++) begin
            @(negedge clk);
            check_true(!boot_done, "boot_done high before the last load word");
            @(posedge clk);
            load_valid <= 1'b1;
            load_data  <= image[i];
            load_last  <= (i == IMG_WORDS - 1);
            @(posedge clk);
            load_valid <= 1'b0;
            load_last  <= 1'b0;
            gap = `ARM_RAM_WAIT + 1 + $urandom_range(0, 3);
            repeat (gap) @(posedge clk);
        end
    endtask

    task automatic wait_boot_done();
        int cycles;
        cycles = 0;
        while (!boot_done && cycles < BOOT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        check_true(boot_done, "boot_done did not rise after the last load word");
    endtask

    task automatic check_retire();
        instr_u      u;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] val;
        logic [31:0] next_pc;
        logic        c;
        logic        v;
        logic        exp_we;
        logic        exp_st;
        check_true(!model_done, "retire seen after the SWI retired");
        if (exec_count == 0) check_eq("first retire_pc", 32'h0, retire_pc);
        check_eq("retire_pc", m_pc, retire_pc);
        u.raw = mem_model[int'(m_pc >> 2)];
        check_eq("retire_instr", u.raw, retire_instr);
        exp_we  = 1'b0;
        exp_st  = 1'b0;
        next_pc = m_pc + 32'd4;
        exec_count++;
        if (cond_pass(u.raw[31:28])) begin
            if (u.raw[27:24] == 4'hF) begin
                model_done = 1'b1;
            end else if (u.raw[27:26] == 2'b01) begin
                addr = reg_read(u.ls.rn) + {20'h0, u.ls.offset12};
                word = mem_model[int'(addr >> 2)];
                if (u.ls.l) begin
                    val    = u.ls.b ? {24'h0, word[8 * addr[1:0] +: 8]} : word;
                    exp_we = 1'b1;
                    check_eq("load rd", u.ls.rd, retire_rd);
                    check_eq("load value", val, retire_rd_value);
                    m_regs[u.ls.rd] = val;
                end else begin
                    val    = reg_read(u.ls.rd);
                    exp_st = 1'b1;
                    check_eq("store addr", addr, retire_addr);
                    check_eq("store data", u.ls.b ? {24'h0, val[7:0]} : val, retire_st_data);
                    check_eq("store size", u.ls.b ? SIZE_BYTE : SIZE_WORD, retire_st_size);
                    if (u.ls.b) word[8 * addr[1:0] +: 8] = val[7:0];
                    else word = val;
                    mem_model[int'(addr >> 2)] = word;
                end
            end else if (u.raw[27:25] == 3'b101) begin
                next_pc = m_pc + 32'd8 + 32'($signed(u.br.offset24) * 4);
            end else begin
                a = reg_read(u.dp.rn);
                b = u.dp.imm ? {24'h0, u.dp.operand2[7:0]} : reg_read(u.dp.operand2[3:0]);
                c = m_c;
                v = m_v;
                case (u.dp.opcode)
                    DP_AND: res = a & b;
                    DP_ORR: res = a | b;
                    DP_MOV: res = b;
                    DP_ADD: begin
                        res = a + b;
                        c   = res < a;   // Unsigned wrap means carry out
                        v   = (a[31] == b[31]) && (res[31] != a[31]);
                    end
                    default: begin
                        res = a - b;
                        c   = a >= b;   // No borrow
                        v   = (a[31] != b[31]) && (res[31] != a[31]);
                    end
                endcase
                if (u.dp.opcode != DP_CMP) begin
                    exp_we = 1'b1;
                    check_eq("alu rd", u.dp.rd, retire_rd);
                    check_eq("alu value", res, retire_rd_value);
                    m_regs[u.dp.rd] = res;
                end
                if (u.dp.s || u.dp.opcode == DP_CMP) begin
                    m_n = res[31];
                    m_z = (res == 32'h0);
                    m_c = c;
                    m_v = v;
                end
            end
        end
        check_eq("retire_rd_we", exp_we, retire_rd_we);
        check_eq("retire_st", exp_st, retire_st);
        m_pc = next_pc;
    endtask

    task automatic run_until_halt();
        int cycles;
        int swi_cycle;
        cycles    = 0;
        swi_cycle = -1;
        while (!halted && cycles < RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (retire_valid) begin
                check_retire();
                if (model_done && swi_cycle < 0) swi_cycle = cycles;
            end
        end
        check_true(halted, "halted did not rise before the run timeout");
        check_true(model_done, "halted rose before the SWI retired");
        check_eq("halted delay", swi_cycle + 1, cycles);
        check_eq("retire count", exec_count, retire_count);
    endtask

    task automatic check_quiet();
        repeat (QUIET) begin
            @(negedge clk);
            check_true(!retire_valid, "retire seen while halted");
            check_true(halted, "halted dropped after the SWI");
        end
    endtask

    initial begin
        int seed_val;
        rst_n      = 1'b0;
        load_valid = 1'b0;
        load_data  = 32'h0;
        load_last  = 1'b0;
        seed_val   = $urandom(41788);
        for (int t = 0; t < NUM_TESTS; t++) begin
            test_name = $sformatf("random_program_%0d", t);
            build_program();
            reset_model();
            apply_reset();
            stream_image();
            wait_boot_done();
            run_until_halt();
            check_quiet();
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/arm_pkg.sv
hdl/mem_bus_if.sv
hdl/boot_loader.sv
hdl/basic_ram.sv
hdl/arm_core.sv
hdl/arm_system.sv
dv/tb_clock_gen.sv
dv/tb_arm_system.sv

// File: Bender.yml
package:
  name: arm_system

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/arm_pkg.sv
      - hdl/mem_bus_if.sv
      - hdl/boot_loader.sv
      - hdl/basic_ram.sv
      - hdl/arm_core.sv
      - hdl/arm_system.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/tb_clock_gen.sv
      - dv/tb_arm_system.sv
